/* Makefile */
VERILATOR ?= verilator
TOP ?= wordStoreTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MESSAGE ?= ** PASS **

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@output="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qF -- '$(PASS_MESSAGE)'

clean:
	rm -rf $(BUILD_DIR)

/* hw/byteLoader.sv */
`timescale 1ns/1ps

module byteLoader
(
	input logic clock,
	input logic rstN,

	// Load control
	input logic loadStart,
	input wordStorePkg::addrT loadBase,

	// Byte stream
	input logic byteValid,
	input logic [7:0] byteData,

	// Write port of the memory
	output wordStorePkg::memWriteT memWrite
);
	import wordStorePkg::*;

	// Position of the next byte within its group
	logic [1:0] byteIndex;
	// Bytes 0 to 2 of the group being built
	logic [23:0] partialWord;
	// Where the next complete word goes
	addrT nextAddress;

	// Registered write toward the memory
	logic writeEnable;
	addrT writeAddress;
	wordT writeData;

	// Control state
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			byteIndex <= 2'd0;
			nextAddress <= '0;
			writeEnable <= 1'b0;
		end
		else
		begin
			// Write enable is a single-cycle strobe
			writeEnable <= 1'b0;
			if (loadStart)
			begin
				// Any partial group is dropped here
				byteIndex <= 2'd0;
				nextAddress <= loadBase;
			end
			else if (byteValid)
			begin
				byteIndex <= byteIndex + 2'd1;
				if (byteIndex == 2'd3)
				begin
					writeEnable <= 1'b1;
					// Wraps at the top of memory
					nextAddress <= nextAddress + 1'b1;
				end
			end
		end
	end

	// Payload, little-endian packing
	always_ff @(posedge clock)
	begin
		if (byteValid && !loadStart)
		begin
			if (byteIndex == 2'd3)
			begin
				// Fourth byte lands in the top lane
				writeData <= {byteData, partialWord};
				writeAddress <= nextAddress;
			end
			else
				partialWord[{byteIndex, 3'b000} +: 8] <= byteData;
		end
	end

	assign memWrite = '{enable: writeEnable, address: writeAddress, data: writeData};

	// Stray X on the strobe would corrupt the byte count
	byteValidKnown: assert property (@(posedge clock) disable iff (!rstN)
		!$isunknown(byteValid));

endmodule

/* hw/dualReadRam.sv */
`timescale 1ns/1ps

module dualReadRam
#(
	parameter int addrBits = wordStorePkg::addrWidth
)
(
	input logic clock,

	// Write port
	input wordStorePkg::memWriteT memWrite,

	// Read port A
	input logic [addrBits-1:0] readAddressA,
	output wordStorePkg::wordT dataOutA,

	// Read port B
	input logic [addrBits-1:0] readAddressB,
	output wordStorePkg::wordT dataOutB
);
	import wordStorePkg::*;

	localparam int depth = 2 ** addrBits;

	// Storage array, contents undefined until loaded
	wordT storage [depth];

	// One write and two reads per edge
	always_ff @(posedge clock)
	begin
		if (memWrite.enable)
			storage[memWrite.address] <= memWrite.data;

		// Reads see the word from before this edge
		dataOutA <= storage[readAddressA];
		dataOutB <= storage[readAddressB];
	end

endmodule

/* hw/pairReducer.sv */
`timescale 1ns/1ps

module pairReducer
(
	input logic clock,
	input logic rstN,

	// Request side
	input logic reduceStart,
	input wordStorePkg::reduceReqT reduceReq,

	// Memory read ports
	output wordStorePkg::addrT readAddressA,
	output wordStorePkg::addrT readAddressB,
	input wordStorePkg::wordT dataA,
	input wordStorePkg::wordT dataB,

	// Status and result
	output logic busy,
	output logic done,
	output wordStorePkg::reduceResT result
);
	import wordStorePkg::*;

	reducerStateT state;

	// Opcode held for the whole request
	reduceOpT opcode;
	// Address of the even word of the current pair
	addrT issueAddress;
	// Pairs still to be issued, counting the current one
	addrT pairsLeft;
	// High when dataA and dataB hold a pair to fold
	logic dataValid;
	wordT accumulator;

	// Pair addresses come straight from the issue register
	assign readAddressA = issueAddress;
	assign readAddressB = issueAddress + 1'b1;

	assign busy = (state != idle);
	assign result = '{value: accumulator, opcode: opcode};

	// FSM and pipeline control
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= idle;
			dataValid <= 1'b0;
			done <= 1'b0;
			pairsLeft <= '0;
		end
		else
		begin
			done <= 1'b0;
			// Read data shows up one edge after its address
			dataValid <= (state == issue);
			case (state)
				idle:
				begin
					// Start while busy never reaches this branch
					if (reduceStart)
					begin
						state <= issue;
						pairsLeft <= reduceReq.pairCount;
					end
				end
				issue:
				begin
					pairsLeft <= pairsLeft - 1'b1;
					if (pairsLeft == addrT'(1))
						state <= drain;
				end
				drain:
				begin
					// Last pair already folded once dataValid drops
					if (!dataValid)
					begin
						done <= 1'b1;
						state <= idle;
					end
				end
				default:
					state <= idle;
			endcase
		end
	end

	// Address walk and accumulator
	always_ff @(posedge clock)
	begin
		if (state == idle && reduceStart)
		begin
			opcode <= reduceReq.opcode;
			issueAddress <= reduceReq.base;
			// Zero is the identity of both sum and xor
			accumulator <= '0;
		end
		else
		begin
			if (state == issue)
				issueAddress <= issueAddress + addrT'(2);
			if (dataValid)
			begin
				case (opcode)
					opSum: accumulator <= accumulator + dataA + dataB;
					opXor: accumulator <= accumulator ^ dataA ^ dataB;
				endcase
			end
		end
	end

	// Requester must wait for busy to fall
	noStartWhileBusy: assert property (@(posedge clock) disable iff (!rstN)
		reduceStart |-> !busy);

	pairCountNonZero: assert property (@(posedge clock) disable iff (!rstN)
		reduceStart |-> (reduceReq.pairCount != '0));

	// Odd base would split pairs across the wrong words
	baseIsEven: assert property (@(posedge clock) disable iff (!rstN)
		reduceStart |-> !reduceReq.base[0]);

	doneSinglePulse: assert property (@(posedge clock) disable iff (!rstN)
		done |=> !done);

endmodule

/* hw/wordStore.sv */
`timescale 1ns/1ps

module wordStore
(
	input logic clock,
	input logic rstN,

	// Byte load side
	input logic loadStart,
	input wordStorePkg::addrT loadBase,
	input logic byteValid,
	input logic [7:0] byteData,

	// Reduction side
	input logic reduceStart,
	input wordStorePkg::reduceReqT reduceReq,
	output logic busy,
	output logic done,
	output wordStorePkg::reduceResT result
);
	import wordStorePkg::*;

	// Loader to memory
	memWriteT memWrite;

	// Reducer to memory and back
	addrT readAddressA;
	addrT readAddressB;
	wordT dataA;
	wordT dataB;

	byteLoader byteLoader_i
	(
		.clock(clock),
		.rstN(rstN),
		.loadStart(loadStart),
		.loadBase(loadBase),
		.byteValid(byteValid),
		.byteData(byteData),
		.memWrite(memWrite)
	);

	dualReadRam #(.addrBits(addrWidth)) dualReadRam_i
	(
		.clock(clock),
		.memWrite(memWrite),
		.readAddressA(readAddressA),
		.dataOutA(dataA),
		.readAddressB(readAddressB),
		.dataOutB(dataB)
	);

	pairReducer pairReducer_i
	(
		.clock(clock),
		.rstN(rstN),
		.reduceStart(reduceStart),
		.reduceReq(reduceReq),
		.readAddressA(readAddressA),
		.readAddressB(readAddressB),
		.dataA(dataA),
		.dataB(dataB),
		.busy(busy),
		.done(done),
		.result(result)
	);

endmodule

/* hw/wordStorePkg.sv */
package wordStorePkg;

	// Word address width, 64 words in the store
	localparam int addrWidth = 6;
	localparam int wordWidth = 32;

	typedef logic [addrWidth-1:0] addrT;
	typedef logic [wordWidth-1:0] wordT;

	// Reduction opcodes
	typedef enum logic
	{
		opSum = 1'b0,
		opXor = 1'b1
	} reduceOpT;

	// One write from the byte loader into the memory
	typedef struct packed
	{
		logic enable;
		addrT address;
		wordT data;
	} memWriteT;

	// Region to fold, base must be even and pairCount non-zero
	typedef struct packed
	{
		reduceOpT opcode;
		addrT base;
		addrT pairCount;
	} reduceReqT;

	// Final value along with the opcode that produced it
	typedef struct packed
	{
		wordT value;
		reduceOpT opcode;
	} reduceResT;

	typedef enum logic [1:0]
	{
		idle,
		issue,
		drain
	} reducerStateT;

endpackage

/* testbench/clockGen.sv */
`timescale 1ns/1ps

module clockGen
(
	output logic clock,
	output logic rstN
);
	// 8 ns period
	localparam int halfPeriod = 4;
	localparam int resetCycles = 4;

	initial
	begin
		clock = 1'b0;
		forever #(halfPeriod) clock = ~clock;
	end

	// Power-on reset, released on a falling edge
	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
	end

endmodule

/* testbench/wordStoreTb.sv */
`timescale 1ns/1ps

module wordStoreTb;
	import wordStorePkg::*;

	// Cycle budget per test, roughly
	localparam int testCycles = (64 * 4 + 40) + (4 * 24) + (8 * 4 + 30) + (2 + 4 * 4 + 20)
		+ (8 * 5 + 10) + (30 + 10 + 30);
	localparam int watchdogNs = (testCycles * 4 + 200) * 8;

	logic clock;
	logic powerOnRstN;
	logic softRstN;
	logic rstN;
	logic loadStart;
	addrT loadBase;
	logic byteValid;
	logic [7:0] byteData;
	logic reduceStart;
	reduceReqT reduceReq;
	logic busy;
	logic done;
	reduceResT result;

	// Mirror of what the memory should hold
	wordT shadow [64];
	logic [31:0] lcgState = 32'd52399;

	// Request the monitor is waiting on
	logic pending = 1'b0;
	string testName = "";
	wordT expValue;
	reduceOpT expOpcode;
	int expLatency;
	int startEdge;

	int cycleCount = 0;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int errorsAtStart = 0;

	// Mid-test reset combines with the power-on one
	assign rstN = powerOnRstN & softRstN;

	clockGen clockGen_i (.clock(clock), .rstN(powerOnRstN));

	wordStore wordStore_i
	(
		.clock(clock),
		.rstN(rstN),
		.loadStart(loadStart),
		.loadBase(loadBase),
		.byteValid(byteValid),
		.byteData(byteData),
		.reduceStart(reduceStart),
		.reduceReq(reduceReq),
		.busy(busy),
		.done(done),
		.result(result)
	);

	always @(posedge clock)
		cycleCount <= cycleCount + 1;

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Expected fold over 2*pairs words, addresses wrap at 64
	function automatic wordT referenceReduce(input wordT memory [64], input reduceOpT op,
		input addrT base, input addrT pairs);
		wordT acc;
		addrT address;
		acc = '0;
		for (int i = 0; i < 2 * int'(pairs); i++)
		begin
			address = addrT'(int'(base) + i);
			if (op == opSum)
				acc = acc + memory[address];
			else
				acc = acc ^ memory[address];
		end
		return acc;
	endfunction

	task automatic checkValues(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic beginTest(input string name);
		testCount++;
		errorsAtStart = errorCount;
		testName = name;
	endtask

	task automatic endTest(input string name);
		if (errorCount == errorsAtStart)
			$display("test %0d %s ok", testCount, name);
		else
			$display("test %0d %s failed with %0d errors", testCount, name,
				errorCount - errorsAtStart);
	endtask

	// All stimulus tasks start and end on a falling edge
	task automatic startLoad(input addrT base);
		loadStart = 1'b1;
		loadBase = base;
		@(negedge clock);
		loadStart = 1'b0;
	endtask

	task automatic sendByte(input logic [7:0] value, input int gap);
		byteValid = 1'b1;
		byteData = value;
		@(negedge clock);
		byteValid = 1'b0;
		repeat (gap) @(negedge clock);
	endtask

	task automatic loadWords(input addrT base, input int count, input int maxGap);
		logic [31:0] r;
		wordT packedWord;
		int gap;
		startLoad(base);
		for (int w = 0; w < count; w++)
		begin
			packedWord = '0;
			for (int b = 0; b < 4; b++)
			begin
				r = nextRandom();
				gap = (maxGap == 0) ? 0 : int'(r[31:24] % 8'(maxGap + 1));
				// First byte goes to the least significant lane
				packedWord[8 * b +: 8] = r[15:8];
				sendByte(r[15:8], gap);
			end
			shadow[addrT'(int'(base) + w)] = packedWord;
		end
		// Last write lands two edges after its fourth byte
		repeat (2) @(negedge clock);
	endtask

	task automatic issueRequest(input reduceOpT op, input addrT base, input addrT pairs);
		expValue = referenceReduce(shadow, op, base, pairs);
		expOpcode = op;
		expLatency = int'(pairs) + 2;
		// Start is taken on the coming rising edge
		startEdge = cycleCount + 1;
		pending = 1'b1;
		reduceReq = '{opcode: op, base: base, pairCount: pairs};
		reduceStart = 1'b1;
		@(negedge clock);
		reduceStart = 1'b0;
	endtask

	task automatic waitDone(input int limit);
		int waited;
		waited = 0;
		while (pending && waited < limit)
		begin
			@(posedge clock);
			waited++;
		end
		if (pending)
		begin
			$display("no done for %s, busy never fell", testName);
			errorCount++;
			pending = 1'b0;
		end
		@(negedge clock);
	endtask

	task automatic runReduce(input reduceOpT op, input addrT base, input addrT pairs);
		issueRequest(op, base, pairs);
		waitDone(int'(pairs) + 10);
	endtask

	// Compares every done against the pending request
	always @(negedge clock)
	begin
		if (rstN && done)
		begin
			if (!pending)
			begin
				$display("done arrived while no request was pending");
				errorCount++;
			end
			else
			begin
				checkValues({testName, " value"}, expValue, result.value);
				checkValues({testName, " opcode"}, 32'(expOpcode), 32'(result.opcode));
				checkValues({testName, " latency"}, 32'(expLatency), 32'(cycleCount - startEdge));
				checkValues({testName, " busy at done"}, 32'(0), 32'(busy));
				pending = 1'b0;
			end
		end
	end

	initial
	begin
		#(watchdogNs);
		$display("watchdog expired, tests did not finish in time");
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		logic [31:0] r;
		addrT base;
		addrT pairs;
		softRstN = 1'b1;
		loadStart = 1'b0;
		loadBase = '0;
		byteValid = 1'b0;
		byteData = '0;
		reduceStart = 1'b0;
		reduceReq = '0;
		wait (powerOnRstN);
		@(negedge clock);

		beginTest("full sum");
		checkValues("reset done", 32'(0), 32'(done));
		checkValues("reset busy", 32'(0), 32'(busy));
		loadWords(addrT'(0), 64, 0);
		runReduce(opSum, addrT'(0), addrT'(32));
		endTest("full sum");

		beginTest("xor regions");
		for (int k = 0; k < 4; k++)
		begin
			r = nextRandom();
			base = {r[5:1], 1'b0};
			pairs = addrT'({2'b00, r[11:8]}) + addrT'(1);
			testName = $sformatf("xor region %0d", k);
			runReduce(opXor, base, pairs);
		end
		endTest("xor regions");

		// Region 60 to 3 crosses the top of memory
		beginTest("address wrap");
		loadWords(addrT'(60), 8, 0);
		runReduce(opSum, addrT'(60), addrT'(4));
		testName = "address wrap xor";
		runReduce(opXor, addrT'(60), addrT'(4));
		endTest("address wrap");

		beginTest("interrupted load");
		startLoad(addrT'(10));
		sendByte(8'hA5, 0);
		sendByte(8'h5A, 0);
		loadWords(addrT'(20), 4, 0);
		runReduce(opSum, addrT'(20), addrT'(2));
		endTest("interrupted load");

		beginTest("single pair timing");
		loadWords(addrT'(32), 2, 4);
		runReduce(opSum, addrT'(32), addrT'(1));
		endTest("single pair timing");

		beginTest("reset mid reduction");
		issueRequest(opSum, addrT'(0), addrT'(20));
		repeat (5) @(negedge clock);
		checkValues("busy before reset", 32'(1), 32'(busy));
		softRstN = 1'b0;
		pending = 1'b0;
		@(negedge clock);
		checkValues("done in reset", 32'(0), 32'(done));
		checkValues("busy in reset", 32'(0), 32'(busy));
		softRstN = 1'b1;
		@(negedge clock);
		checkValues("busy after reset", 32'(0), 32'(busy));
		testName = "after reset";
		runReduce(opXor, addrT'(0), addrT'(20));
		endTest("reset mid reduction");

		$display("tests %0d checks %0d errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* verilog.f */
hw/wordStorePkg.sv
hw/byteLoader.sv
hw/dualReadRam.sv
hw/pairReducer.sv
hw/wordStore.sv
testbench/clockGen.sv
testbench/wordStoreTb.sv
